// ==== design/brq_dispatch.sv ====
`timescale 1ns/1ps

module brq_dispatch
    import brq_pkg::*;
#(
    parameter int DEPTH = 11
) (
    input  logic [DEPTH-1:0]      slotValid,
    input  unitCode_e [DEPTH-1:0] slotSource,
    input  logic [DEPTH-1:0][3:0] slotDest,
    input  logic [NUM_FREE-1:0]   free,
    input  logic                  pull,
    output logic [DEPTH-1:0]      remove,
    output logic                  reqReady,
    output unitCode_e             sendOut
);

    logic [DEPTH-1:0] unitFree;
    logic [DEPTH-1:0] slotReady;
    logic [3:0]       sendBits;

    // decode each destination onto its unit's free level
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            case (slotDest[i])
                UNIT_IE:  unitFree[i] = free[FREE_IE];
                UNIT_IO:  unitFree[i] = free[FREE_IO];
                UNIT_DE:  unitFree[i] = free[FREE_DE];
                UNIT_DO:  unitFree[i] = free[FREE_DO];
                UNIT_B0:  unitFree[i] = free[FREE_B0];
                UNIT_B1:  unitFree[i] = free[FREE_B1];
                UNIT_B2:  unitFree[i] = free[FREE_B2];
                UNIT_B3:  unitFree[i] = free[FREE_B3];
                UNIT_DMA: unitFree[i] = free[FREE_DMA];
                // unknown codes never get dispatched
                default:  unitFree[i] = 1'b0;
            endcase
        end
    end

    assign slotReady = slotValid & unitFree & {DEPTH{pull}};

    // oldest ready slot wins, which is the highest index
    always_comb begin
        remove = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (slotReady[i]) begin
                remove    = '0;
                remove[i] = 1'b1;
            end
        end
    end

    // and-or mux on the one-hot pick
    always_comb begin
        sendBits = 4'h0;
        for (int i = 0; i < DEPTH; i++) begin
            sendBits = sendBits | (slotSource[i] & {4{remove[i]}});
        end
    end

    assign sendOut  = unitCode_e'(sendBits);
    assign reqReady = |slotReady;

endmodule

// ==== design/brq_intake.sv ====
`timescale 1ns/1ps

module brq_intake
    import brq_pkg::*;
(
    input  logic [NUM_REQ-1:0]      req,
    input  logic [NUM_REQ-1:0][3:0] dest,
    input  logic                    accept,
    output logic [NUM_REQ-1:0]      ack,
    output logic                    newValid,
    output unitCode_e               newSource,
    output logic [3:0]              newDest
);

    localparam int IDX_W = $clog2(NUM_REQ);

    logic [NUM_REQ-1:0] grant;
    logic [IDX_W-1:0]   winner;

    // fixed priority, the highest active index wins
    always_comb begin
        grant  = '0;
        winner = '0;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (req[i]) begin
                grant     = '0;
                grant[i]  = 1'b1;
                winner    = IDX_W'(i);
            end
        end
    end

    assign newValid = |req;

    // the entry carries the requester's return code and its destination
    assign newSource = REQ_UNIT[winner];
    assign newDest   = dest[winner];

    // no ack while the queue cannot take slot 0
    assign ack = grant & {NUM_REQ{accept}};

endmodule

// ==== design/brq_pkg.sv ====
package brq_pkg;

    // bus unit codes, top two bits are the domain and low two the subdomain
    typedef enum logic [3:0] {
        UNIT_IO  = 4'd1,
        UNIT_IE  = 4'd2,
        UNIT_DO  = 4'd5,
        UNIT_DE  = 4'd6,
        UNIT_B0  = 4'd8,
        UNIT_B1  = 4'd9,
        UNIT_B2  = 4'd10,
        UNIT_B3  = 4'd11,
        UNIT_DMA = 4'd12
    } unitCode_e;

    // requesters, index 10 is DMA down to B3 at index 0
    localparam int NUM_REQ = 11;

    // one free level per unit
    localparam int NUM_FREE = 9;

    localparam int FREE_IE  = 8;
    localparam int FREE_IO  = 7;
    localparam int FREE_DE  = 6;
    localparam int FREE_DO  = 5;
    localparam int FREE_B0  = 4;
    localparam int FREE_B1  = 3;
    localparam int FREE_B2  = 2;
    localparam int FREE_B3  = 1;
    localparam int FREE_DMA = 0;

    // return unit per requester, listed from index 0 (B3) up to index 10 (DMA)
    localparam unitCode_e REQ_UNIT [0:NUM_REQ-1] = '{
        UNIT_B3,
        UNIT_B2,
        UNIT_B1,
        UNIT_B0,
        UNIT_DO,
        UNIT_DO,
        UNIT_DE,
        UNIT_DE,
        UNIT_IO,
        UNIT_IE,
        UNIT_DMA
    };

endpackage

// ==== design/brq_queue.sv ====
`timescale 1ns/1ps

module brq_queue
    import brq_pkg::*;
#(
    parameter int DEPTH = 11
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  newValid,
    input  unitCode_e             newSource,
    input  logic [3:0]            newDest,
    input  logic [DEPTH-1:0]      remove,
    output logic                  accept,
    output logic [DEPTH-1:0]      slotValid,
    output unitCode_e [DEPTH-1:0] slotSource,
    output logic [DEPTH-1:0][3:0] slotDest
);

    logic [DEPTH-1:0]      slotGap;
    logic [DEPTH-1:0]      slotLoad;
    logic [DEPTH-1:0]      shiftValid;
    unitCode_e [DEPTH-1:0] shiftSource;
    logic [DEPTH-1:0][3:0] shiftDest;

    // a slot opens when it is empty or its entry leaves this cycle
    assign slotGap = ~slotValid | remove;

    // load when this slot or any older one opens, slot DEPTH-1 is the oldest
    always_comb begin
        slotLoad[DEPTH-1] = slotGap[DEPTH-1];
        for (int i = DEPTH - 2; i >= 0; i--) begin
            slotLoad[i] = slotLoad[i+1] | slotGap[i];
        end
    end

    // each slot takes its younger neighbor, slot 0 takes the new entry
    always_comb begin
        shiftValid[0]  = newValid;
        shiftSource[0] = newSource;
        shiftDest[0]   = newDest;
        for (int i = 1; i < DEPTH; i++) begin
            // a removed entry is dropped while it moves up
            shiftValid[i]  = slotValid[i-1] & ~remove[i-1];
            shiftSource[i] = slotSource[i-1];
            shiftDest[i]   = slotDest[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (slotLoad[i]) begin
                    slotValid[i] <= shiftValid[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (slotLoad[i]) begin
                slotSource[i] <= shiftSource[i];
                slotDest[i]   <= shiftDest[i];
            end
        end
    end

    // slot 0 loads whenever the queue has room after this cycle's removal
    assign accept = slotLoad[0];

endmodule

// ==== design/brq_top.sv ====
`timescale 1ns/1ps

module brq_top
    import brq_pkg::*;
#(
    parameter int DEPTH = 11
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [NUM_REQ-1:0]      req,
    input  logic [NUM_REQ-1:0][3:0] dest,
    input  logic [NUM_FREE-1:0]     free,
    input  logic                    pull,
    output logic [NUM_REQ-1:0]      ack,
    output logic                    reqReady,
    output unitCode_e               sendOut
);

    logic                  newValid;
    unitCode_e             newSource;
    logic [3:0]            newDest;
    logic                  accept;
    logic [DEPTH-1:0]      remove;
    logic [DEPTH-1:0]      slotValid;
    unitCode_e [DEPTH-1:0] slotSource;
    logic [DEPTH-1:0][3:0] slotDest;

    brq_intake intake_i (
        .req       (req),
        .dest      (dest),
        .accept    (accept),
        .ack       (ack),
        .newValid  (newValid),
        .newSource (newSource),
        .newDest   (newDest)
    );

    brq_queue #(
        .DEPTH (DEPTH)
    ) queue_i (
        .clk        (clk),
        .rst        (rst),
        .newValid   (newValid),
        .newSource  (newSource),
        .newDest    (newDest),
        .remove     (remove),
        .accept     (accept),
        .slotValid  (slotValid),
        .slotSource (slotSource),
        .slotDest   (slotDest)
    );

    // removal and intake share the same edge
    brq_dispatch #(
        .DEPTH (DEPTH)
    ) dispatch_i (
        .slotValid  (slotValid),
        .slotSource (slotSource),
        .slotDest   (slotDest),
        .free       (free),
        .pull       (pull),
        .remove     (remove),
        .reqReady   (reqReady),
        .sendOut    (sendOut)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the bus request queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module brq_tb -o brq_sim \
    && ./obj_dir/brq_sim \
    || { echo "simulation failed"; exit 1; }

// ==== tb.f ====
design/brq_pkg.sv
design/brq_intake.sv
design/brq_queue.sv
design/brq_dispatch.sv
design/brq_top.sv
verif/brq_props.sv
verif/brq_tb.sv

// ==== verif/brq_props.sv ====
`timescale 1ns/1ps

module brq_props
    import brq_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic [NUM_REQ-1:0] req,
    input logic [NUM_REQ-1:0] ack,
    input logic               reqReady,
    input logic               pull
);

    logic seenAck;

    // set once the first entry has been taken in after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            seenAck <= 1'b0;
        end else if (|ack) begin
            seenAck <= 1'b1;
        end
    end

    ackOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack))
        else $error("ack has more than one bit set");

    ackHasReq: assert property (@(posedge clk) disable iff (rst) (ack & ~req) == '0)
        else $error("ack given to a requester without a request");

    readyNeedsPull: assert property (@(posedge clk) disable iff (rst) reqReady |-> pull)
        else $error("reqReady raised while pull is low");

    // the queue is empty until an ack has loaded something
    readyAfterAck: assert property (@(posedge clk) disable iff (rst) !seenAck |-> !reqReady)
        else $error("reqReady raised before any request was taken");

endmodule

bind brq_top brq_props props_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .ack      (ack),
    .reqReady (reqReady),
    .pull     (pull)
);

// ==== verif/brq_tb.sv ====
`timescale 1ns/1ps

module brq_tb
    import brq_pkg::*;
;

    localparam int DEPTH = 11;
    localparam int RAND_CYCLES = 3000;
    localparam int DIRECTED_CYCLES = 200;
    localparam int LIMIT_CYCLES = 16 + DIRECTED_CYCLES + RAND_CYCLES + 400;

    logic                    clk = 1'b0;
    logic                    rst;
    logic [NUM_REQ-1:0]      req;
    logic [NUM_REQ-1:0][3:0] dest;
    logic [NUM_FREE-1:0]     free;
    logic                    pull;
    logic [NUM_REQ-1:0]      ack;
    logic                    reqReady;
    unitCode_e               sendOut;

    // model queue, front is the oldest entry
    unitCode_e          modelSrc[$];
    logic [3:0]         modelDst[$];
    string              testName = "reset";
    logic               checkOn = 1'b0;
    logic [NUM_REQ-1:0] ackSeen = '0;
    logic [31:0]        rngState = 32'h39be78c5;
    logic               expReady;
    unitCode_e          expSend;
    int                 expIdx;
    logic [NUM_REQ-1:0] expAck;

    unitCode_e validUnits [0:8] = '{UNIT_IE, UNIT_IO, UNIT_DE, UNIT_DO, UNIT_B0,
                                    UNIT_B1, UNIT_B2, UNIT_B3, UNIT_DMA};

    brq_top #(
        .DEPTH (DEPTH)
    ) dut_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .dest     (dest),
        .free     (free),
        .pull     (pull),
        .ack      (ack),
        .reqReady (reqReady),
        .sendOut  (sendOut)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // free bit 8 is IE down to DMA at bit 0
    function automatic logic unitIsFree(input logic [3:0] d, input logic [NUM_FREE-1:0] f);
        case (d)
            4'd2:    return f[8];
            4'd1:    return f[7];
            4'd6:    return f[6];
            4'd5:    return f[5];
            4'd8:    return f[4];
            4'd9:    return f[3];
            4'd10:   return f[2];
            4'd11:   return f[1];
            4'd12:   return f[0];
            default: return 1'b0;
        endcase
    endfunction

    function automatic void refModel(
        input  unitCode_e           srcQ[$],
        input  logic [3:0]          dstQ[$],
        input  logic [NUM_REQ-1:0]  reqNow,
        input  logic [NUM_FREE-1:0] freeNow,
        input  logic                pullNow,
        output logic                rdy,
        output unitCode_e           send,
        output int                  idx,
        output logic [NUM_REQ-1:0]  ackOut
    );
        logic roomy;
        rdy = 1'b0;
        send = UNIT_IO;
        idx = -1;
        ackOut = '0;
        for (int i = 0; i < srcQ.size(); i++) begin
            if (!rdy && pullNow && unitIsFree(dstQ[i], freeNow)) begin
                rdy = 1'b1;
                send = srcQ[i];
                idx = i;
            end
        end
        // room when a slot is empty or one leaves this cycle
        roomy = (srcQ.size() < DEPTH) || rdy;
        for (int r = NUM_REQ - 1; r >= 0; r--) begin
            if (roomy && reqNow[r] && ackOut == '0) begin
                ackOut[r] = 1'b1;
            end
        end
    endfunction

    task automatic checkAck(input logic [NUM_REQ-1:0] exp, input logic [NUM_REQ-1:0] act);
        if (exp !== act) begin
            $display("ERR %s ack expected %0h actual %0h", testName, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "ack mismatch");
        end
    endtask

    task automatic checkReady(input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s reqReady expected %0b actual %0b", testName, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "reqReady mismatch");
        end
    endtask

    task automatic checkUnit(input unitCode_e exp, input unitCode_e act);
        if (exp !== act) begin
            $display("ERR %s sendOut expected %0h actual %0h", testName, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "sendOut mismatch");
        end
    endtask

    // compare just before each rising edge, then advance the model
    initial begin
        forever begin
            @(posedge clk);
            #7;
            if (checkOn) begin
                refModel(modelSrc, modelDst, req, free, pull, expReady, expSend, expIdx, expAck);
                checkAck(expAck, ack);
                checkReady(expReady, reqReady);
                if (expReady) begin
                    checkUnit(expSend, sendOut);
                end
                ackSeen = ack;
                if (expIdx >= 0) begin
                    modelSrc.delete(expIdx);
                    modelDst.delete(expIdx);
                end
                for (int r = 0; r < NUM_REQ; r++) begin
                    if (expAck[r]) begin
                        modelSrc.push_back(REQ_UNIT[r]);
                        modelDst.push_back(dest[r]);
                    end
                end
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", LIMIT_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    // requesters hold their level until acked
    task automatic stepCycle();
        @(posedge clk);
        #1;
        req = req & ~ackSeen;
    endtask

    task automatic waitEmpty();
        while (modelSrc.size() != 0 || req != '0) begin
            stepCycle();
        end
    endtask

    task automatic raiseAll();
        for (int r = 0; r < NUM_REQ; r++) begin
            dest[r] = validUnits[r % 9];
        end
        req = '1;
        while (req != '0) begin
            stepCycle();
        end
    endtask

    initial begin
        rst = 1'b1;
        req = '0;
        dest = '0;
        free = '1;
        pull = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        checkOn = 1'b1;

        testName = "idle";
        repeat (4) stepCycle();

        testName = "priority";
        raiseAll();

        testName = "order";
        pull = 1'b1;
        waitEmpty();

        testName = "blocked";
        free = 9'h1bf;
        dest[10] = UNIT_DE;
        dest[9] = UNIT_B0;
        dest[8] = UNIT_DE;
        dest[7] = UNIT_B1;
        dest[6] = UNIT_DE;
        dest[5] = UNIT_B2;
        req = 11'h7e0;
        while (req != '0) begin
            stepCycle();
        end
        repeat (4) stepCycle();
        pull = 1'b0;
        free = '1;
        repeat (4) stepCycle();
        pull = 1'b1;
        waitEmpty();

        testName = "full";
        pull = 1'b0;
        raiseAll();
        req[10:8] = 3'b111;
        repeat (4) stepCycle();
        pull = 1'b1;
        stepCycle();
        pull = 1'b0;
        repeat (3) stepCycle();
        pull = 1'b1;
        waitEmpty();

        testName = "random";
        for (int c = 0; c < RAND_CYCLES; c++) begin
            stepCycle();
            for (int r = 0; r < NUM_REQ; r++) begin
                rngState = xorshift(rngState);
                if (!req[r] && rngState[3:0] < 4'd3) begin
                    req[r] = 1'b1;
                    dest[r] = validUnits[rngState[11:8] % 9];
                end
            end
            rngState = xorshift(rngState);
            free = rngState[20:12];
            pull = rngState[31:29] != 3'd0;
        end
        free = '1;
        pull = 1'b1;
        waitEmpty();

        // a code that names no unit stays queued for good
        testName = "unknown";
        dest[0] = 4'd3;
        req[0] = 1'b1;
        repeat (6) stepCycle();

        repeat (2) stepCycle();
        $display("NO ERRORS");
        $finish;
    end

endmodule
